//--- design/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

   // width of one stored word
   localparam int DATA_WIDTH = 16;

   // words held by the storage array, a power of two
   localparam int DEPTH = 16;

   // pointers wrap on their own at DEPTH
   localparam int PTR_WIDTH = $clog2(DEPTH);

   // word count must reach DEPTH itself
   localparam int CNT_WIDTH = $clog2(DEPTH + 1);

   // one stored word
   typedef logic [DATA_WIDTH-1:0] data_t;

endpackage

//--- design/fifo_storage.sv
`timescale 1ns/1ps

module fifo_storage (
   input  logic                rd_clk,
   input  logic                reset_i,
   input  logic                wr_en_i,
   input  fifo_cfg_pkg::data_t wr_data_i,
   input  logic                ram_rd_en_i,
   output fifo_cfg_pkg::data_t ram_data_o,
   output logic                ram_empty_o,
   output logic                full_o
);

   import fifo_cfg_pkg::*;

   // word array, no reset needed on payload
   data_t mem [DEPTH];

   logic [PTR_WIDTH-1:0] wr_ptr;
   logic [PTR_WIDTH-1:0] rd_ptr;
   logic [CNT_WIDTH-1:0] word_cnt;

   // qualified requests
   logic wr_ok;
   logic rd_ok;

   // flags straight from the count
   assign full_o      = (word_cnt == CNT_WIDTH'(DEPTH));
   assign ram_empty_o = (word_cnt == '0);

   // writes while full are dropped
   assign wr_ok = wr_en_i & ~full_o;
   // preload only reads with words present, guard anyway
   assign rd_ok = ram_rd_en_i & ~ram_empty_o;

   // array write
   always_ff @(posedge rd_clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   // registered read port, this is stage 1 data
   // holds its word until the next accepted read
   always_ff @(posedge rd_clk) begin
      if (rd_ok) begin
         ram_data_o <= mem[rd_ptr];
      end
   end

   // pointers, wrap is natural since DEPTH is a power of two
   always_ff @(posedge rd_clk) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // word count
   // read and write together leave it alone
   always_ff @(posedge rd_clk) begin
      if (reset_i) begin
         word_cnt <= '0;
      end else begin
         case ({wr_ok, rd_ok})
            2'b10:   word_cnt <= word_cnt + 1'b1;
            2'b01:   word_cnt <= word_cnt - 1'b1;
            default: word_cnt <= word_cnt;
         endcase
      end
   end

endmodule

//--- design/fwft_fifo_top.sv
`timescale 1ns/1ps

module fwft_fifo_top (
   input  logic                        rd_clk,
   input  logic                        reset_i,
   input  logic                        wr_en_i,
   input  fifo_cfg_pkg::data_t         wr_data_i,
   output logic                        full_o,
   input  logic                        rd_en_i,
   output fifo_cfg_pkg::data_t         rd_data_o,
   output logic                        valid_o,
   output logic                        empty_o,
   output logic                        almost_empty_o,
   output logic                        underflow_o,
   output fwft_types_pkg::fwft_state_t valid_stages_o
);

   import fifo_cfg_pkg::*;

   // storage to preload link
   logic  ram_rd_en;
   logic  ram_empty;
   data_t ram_data;

   // preload state seen by the flags
   preload_status_if status_if ();

   assign status_if.rd_en     = rd_en_i;
   assign status_if.ram_empty = ram_empty;

   // stage 2 valid is the user valid
   assign valid_o = status_if.read_data_valid;

   fifo_storage u_storage (
      .rd_clk      (rd_clk),
      .reset_i     (reset_i),
      .wr_en_i     (wr_en_i),
      .wr_data_i   (wr_data_i),
      .ram_rd_en_i (ram_rd_en),
      .ram_data_o  (ram_data),
      .ram_empty_o (ram_empty),
      .full_o      (full_o)
   );

   fwft_preload u_preload (
      .rd_clk         (rd_clk),
      .reset_i        (reset_i),
      .rd_en_i        (rd_en_i),
      .ram_data_i     (ram_data),
      .ram_empty_i    (ram_empty),
      .ram_rd_en_o    (ram_rd_en),
      .rd_data_o      (rd_data_o),
      .valid_stages_o (valid_stages_o),
      .status         (status_if.preload)
   );

   read_status u_status (
      .rd_clk         (rd_clk),
      .reset_i        (reset_i),
      .status         (status_if.status),
      .empty_o        (empty_o),
      .almost_empty_o (almost_empty_o),
      .underflow_o    (underflow_o)
   );

endmodule

//--- design/fwft_preload.sv
`timescale 1ns/1ps

module fwft_preload (
   input  logic                      rd_clk,
   input  logic                      reset_i,
   input  logic                      rd_en_i,
   input  fifo_cfg_pkg::data_t       ram_data_i,
   input  logic                      ram_empty_i,
   output logic                      ram_rd_en_o,
   output fifo_cfg_pkg::data_t       rd_data_o,
   output fwft_types_pkg::fwft_state_t valid_stages_o,
   preload_status_if.preload         status
);

   import fwft_types_pkg::*;

   fwft_state_t curr_state;
   fwft_state_t next_state;

   // stage valid bits
   logic ram_valid;
   logic read_data_valid;

   // stage update requests
   logic preload_stage1;
   logic preload_stage2;

   // stage 2 refills when stage 1 has a word and stage 2 is free or being read
   assign preload_stage2 = ram_valid & (~read_data_valid | rd_en_i);

   // stage 1 refills when empty or when it hands its word to stage 2
   assign preload_stage1 = (~ram_valid | preload_stage2) & ~ram_empty_i;

   // a user read frees a slot, so pull from storage whenever it has words
   assign ram_rd_en_o = (rd_en_i & ~ram_empty_i) | preload_stage1;

   // stage 1 valid
   // a storage read always fills it, a stage 2 load drains it
   always_ff @(posedge rd_clk) begin
      if (reset_i) begin
         ram_valid <= 1'b0;
      end else if (ram_rd_en_o) begin
         ram_valid <= 1'b1;
      end else if (preload_stage2) begin
         ram_valid <= 1'b0;
      end
   end

   // stage 2 valid
   // filled from stage 1, otherwise kept until read
   always_ff @(posedge rd_clk) begin
      if (reset_i) begin
         read_data_valid <= 1'b0;
      end else begin
         read_data_valid <= ram_valid | (read_data_valid & ~rd_en_i);
      end
   end

   // stage 2 data, the user output register
   always_ff @(posedge rd_clk) begin
      if (preload_stage2) begin
         rd_data_o <= ram_data_i;
      end
   end

   // stage occupancy tracker
   always_comb begin
      case (curr_state)
         INVALID: begin
            next_state = ram_empty_i ? INVALID : STAGE1_VALID;
         end
         // stage 1 word always moves on to stage 2
         STAGE1_VALID: begin
            next_state = ram_empty_i ? STAGE2_VALID : BOTH_STAGES_VALID;
         end
         STAGE2_VALID: begin
            if (ram_empty_i && rd_en_i) begin
               next_state = INVALID;
            end else if (!ram_empty_i && rd_en_i) begin
               next_state = STAGE1_VALID;
            end else if (!ram_empty_i) begin
               next_state = BOTH_STAGES_VALID;
            end else begin
               next_state = STAGE2_VALID;
            end
         end
         // both full, only a read with no refill drops a stage
         BOTH_STAGES_VALID: begin
            next_state = (ram_empty_i && rd_en_i) ? STAGE2_VALID : BOTH_STAGES_VALID;
         end
         default: next_state = INVALID;
      endcase
   end

   always_ff @(posedge rd_clk) begin
      if (reset_i) begin
         curr_state <= INVALID;
      end else begin
         curr_state <= next_state;
      end
   end

   assign valid_stages_o = curr_state;

   // publish for the flag logic
   assign status.ram_valid       = ram_valid;
   assign status.read_data_valid = read_data_valid;
   assign status.stage2_load     = preload_stage2;

endmodule

//--- design/fwft_types_pkg.sv
package fwft_types_pkg;

   // preload stage occupancy
   // bit 1 set means stage 1 holds a word, bit 0 means stage 2 does
   typedef enum logic [1:0] {
      INVALID           = 2'b00,
      STAGE2_VALID      = 2'b01,
      STAGE1_VALID      = 2'b10,
      BOTH_STAGES_VALID = 2'b11
   } fwft_state_t;

endpackage

//--- design/preload_status_if.sv
`timescale 1ns/1ps

interface preload_status_if;

   // stage 1 (storage read register) holds a word
   logic ram_valid;
   // stage 2 (user output register) holds a word
   logic read_data_valid;
   // stage 2 takes the stage 1 word this cycle
   logic stage2_load;
   // user read request, copied from the port
   logic rd_en;
   // storage has no words left
   logic ram_empty;

   // preload stages publish their state
   modport preload (
      output ram_valid,
      output read_data_valid,
      output stage2_load
   );

   // flag logic only looks
   modport status (
      input ram_valid,
      input read_data_valid,
      input stage2_load,
      input rd_en,
      input ram_empty
   );

endinterface

//--- design/read_status.sv
`timescale 1ns/1ps

module read_status (
   input  logic              rd_clk,
   input  logic              reset_i,
   preload_status_if.status  status,
   output logic              empty_o,
   output logic              almost_empty_o,
   output logic              underflow_o
);

   // registered copies for underflow
   logic rd_en_q;
   logic empty_q;

   // almost-empty update condition
   logic ae_update;

   // empty when stage 1 is dry and stage 2 is dry or being read
   always_ff @(posedge rd_clk) begin
      if (reset_i) begin
         empty_o <= 1'b1;
      end else begin
         empty_o <= (~status.ram_valid & ~status.read_data_valid) |
                    (~status.ram_valid & status.rd_en);
      end
   end

   // follow storage empty whenever stage 2 reloads
   // also when output sits unread and storage refills stage 1
   assign ae_update = status.stage2_load |
                      (~status.ram_empty & status.read_data_valid & ~status.rd_en);

   always_ff @(posedge rd_clk) begin
      if (reset_i) begin
         almost_empty_o <= 1'b1;
      end else if (ae_update) begin
         almost_empty_o <= status.ram_empty;
      end
   end

   // one cycle behind the request
   always_ff @(posedge rd_clk) begin
      if (reset_i) begin
         rd_en_q <= 1'b0;
         empty_q <= 1'b1;
      end else begin
         rd_en_q <= status.rd_en;
         empty_q <= empty_o;
      end
   end

   // read request seen while empty
   assign underflow_o = rd_en_q & empty_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# build the FWFT FIFO testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_fwft_fifo -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

# let every assertion failure print instead of stopping at the first
./obj_dir/Vtb_fwft_fifo +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
   echo "simulation passed"
   exit 0
fi
echo "simulation failed, see $LOG"
exit 1

//--- sources.f
design/fifo_cfg_pkg.sv
design/fwft_types_pkg.sv
design/preload_status_if.sv
design/fifo_storage.sv
design/fwft_preload.sv
design/read_status.sv
design/fwft_fifo_top.sv
testbench/fwft_fifo_properties.sv
testbench/tb_fwft_fifo.sv

//--- testbench/fwft_fifo_properties.sv
`timescale 1ns/1ps

module fwft_fifo_properties (
   input logic                        rd_clk,
   input logic                        reset_i,
   input logic                        wr_en_i,
   input logic                        full_o,
   input logic                        rd_en_i,
   input fifo_cfg_pkg::data_t         rd_data_o,
   input logic                        valid_o,
   input logic                        empty_o,
   input logic                        almost_empty_o,
   input logic                        underflow_o,
   input fwft_types_pkg::fwft_state_t valid_stages_o
);

   import fifo_cfg_pkg::*;
   import fwft_types_pkg::*;

   // accepted transfers since reset, written data is the write index
   data_t wr_cnt;
   data_t rd_cnt;
   data_t held;
   // consecutive cycles with three or more words held and no read, saturates
   logic [1:0] deep_cycles;
   int fail_cnt = 0;

   assign held = wr_cnt - rd_cnt;

   always_ff @(posedge rd_clk) begin
      if (reset_i) begin
         wr_cnt      <= '0;
         rd_cnt      <= '0;
         deep_cycles <= '0;
      end else begin
         if (wr_en_i && !full_o) begin
            wr_cnt <= wr_cnt + data_t'(1);
         end
         if (valid_o && rd_en_i) begin
            rd_cnt <= rd_cnt + data_t'(1);
         end
         if ((held < data_t'(3)) || (valid_o && rd_en_i)) begin
            deep_cycles <= 2'd0;
         end else if (deep_cycles != 2'd3) begin
            deep_cycles <= deep_cycles + 2'd1;
         end
      end
   end

   // read side idle and empty after any reset cycle
   reset_idle: assert property (@(posedge rd_clk) reset_i |=> (empty_o && almost_empty_o &&
      !valid_o && !full_o && !underflow_o && valid_stages_o == INVALID))
      else begin fail_cnt++; $error("read side not idle after reset"); end

   // words leave in write order
   read_order: assert property (@(posedge rd_clk) disable iff (reset_i)
      (valid_o && rd_en_i) |-> rd_data_o == rd_cnt)
      else begin fail_cnt++; $error("read word %h, expected %h", rd_data_o, rd_cnt); end

   // read while empty is never taken
   empty_read_refused: assert property (@(posedge rd_clk) disable iff (reset_i)
      (rd_en_i && empty_o) |-> !valid_o)
      else begin fail_cnt++; $error("valid_o high with empty_o"); end

   underflow_follows: assert property (@(posedge rd_clk) disable iff (reset_i)
      (rd_en_i && empty_o) |=> underflow_o)
      else begin fail_cnt++; $error("underflow_o missing"); end

   // exactly one cycle, only after a request while empty
   underflow_cause: assert property (@(posedge rd_clk) disable iff (reset_i)
      underflow_o |-> $past(rd_en_i && empty_o))
      else begin fail_cnt++; $error("underflow_o without a read while empty"); end

   ae_when_empty: assert property (@(posedge rd_clk) disable iff (reset_i)
      empty_o |-> almost_empty_o)
      else begin fail_cnt++; $error("almost_empty_o low while empty_o high"); end

   ae_low_when_deep: assert property (@(posedge rd_clk) disable iff (reset_i)
      (deep_cycles == 2'd3) |-> !almost_empty_o)
      else begin fail_cnt++; $error("almost_empty_o high with three words held"); end

   // stage 2 half of the reported occupancy is the user valid
   stage2_matches_valid: assert property (@(posedge rd_clk) disable iff (reset_i)
      valid_o == (valid_stages_o == STAGE2_VALID || valid_stages_o == BOTH_STAGES_VALID))
      else begin fail_cnt++; $error("valid_stages_o disagrees with valid_o"); end

   // read with stage 1 full, next word shows on the following edge
   read_refill_next_edge: assert property (@(posedge rd_clk) disable iff (reset_i)
      (valid_o && rd_en_i && valid_stages_o == BOTH_STAGES_VALID) |=> valid_o)
      else begin fail_cnt++; $error("no word on the edge after a read with stage 1 full"); end

endmodule

bind fwft_fifo_top fwft_fifo_properties u_props (.*);

//--- testbench/tb_fwft_fifo.sv
`timescale 1ns/1ps

module tb_fwft_fifo;

   import fifo_cfg_pkg::*;
   import fwft_types_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int RESET_CYCLES = 8;
   localparam logic [31:0] LFSR_SEED = 32'hb4b00cfb;
   localparam int NUM_TESTS = 6;
   localparam int TEST_WORDS = 40;
   localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_WORDS * 4 + 200;
   // edges from driving a write, the write edge counted first, to valid_o
   localparam int FALL_EDGES = 3;

   logic        rd_clk;
   logic        reset_i;
   logic        wr_en_i;
   data_t       wr_data_i;
   logic        full_o;
   logic        rd_en_i;
   data_t       rd_data_o;
   logic        valid_o;
   logic        empty_o;
   logic        almost_empty_o;
   logic        underflow_o;
   fwft_state_t valid_stages_o;

   logic [31:0] lfsr;
   // accepted writes and reads, the write index is also the data
   int wr_count;
   int rd_count;
   int errors;
   int tests_done;

   fwft_fifo_top UUT (.*);

   initial begin
      rd_clk = 1'b0;
      forever #(CLK_PERIOD / 2) rd_clk = ~rd_clk;
   end

   // galois form, one step per bit
   function automatic logic random_bit();
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      return lfsr[0];
   endfunction

   task automatic check(input logic ok, input string what);
      assert (ok)
         else begin
            $display("Error at time %0t: %s", $time, what);
            errors++;
         end
   endtask

   // called at the drive point, outputs are settled since the edge
   task automatic run_cycle(input logic wr, input logic rd);
      wr_en_i   = wr;
      wr_data_i = data_t'(wr_count);
      rd_en_i   = rd;
      if (rd && valid_o) begin
         check(rd_data_o == data_t'(rd_count), "read data out of sequence");
         rd_count++;
      end
      if (wr && !full_o) begin
         wr_count++;
      end
      @(posedge rd_clk);
      #5;
   endtask

   task automatic drain();
      while (rd_count < wr_count) begin
         run_cycle(1'b0, 1'b1);
      end
   endtask

   task automatic end_test(input string name);
      tests_done++;
      $display("test %s finished, %0d errors so far", name, errors + UUT.u_props.fail_cnt);
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the run hung and was stopped after %0d clock periods", WATCHDOG_CYCLES);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      int   edges;
      int   saved;
      int   target;
      logic wr_bit;
      logic rd_bit;
      reset_i    = 1'b1;
      wr_en_i    = 1'b0;
      wr_data_i  = '0;
      rd_en_i    = 1'b0;
      lfsr       = LFSR_SEED;
      wr_count   = 0;
      rd_count   = 0;
      errors     = 0;
      tests_done = 0;
      repeat (RESET_CYCLES) @(posedge rd_clk);
      #5;
      reset_i = 1'b0;

      check(empty_o && almost_empty_o, "empty flags low after reset");
      check(!valid_o && !full_o && !underflow_o, "valid, full or underflow high after reset");
      check(valid_stages_o == INVALID, "stage state not INVALID after reset");
      end_test("reset_values");

      // single write into an idle FIFO
      run_cycle(1'b1, 1'b0);
      edges = 1;
      while (!valid_o && edges < FALL_EDGES + 4) begin
         check(empty_o, "empty_o fell before valid_o");
         run_cycle(1'b0, 1'b0);
         edges++;
      end
      check(edges == FALL_EDGES, "valid_o not at the expected edge after the write");
      check(!empty_o, "empty_o still high with valid_o");
      check(rd_data_o == data_t'(rd_count), "first word not on rd_data_o");
      end_test("fall_through");

      drain();
      check(empty_o, "FIFO not empty after draining");
      saved = rd_count;
      run_cycle(1'b0, 1'b1);
      check(underflow_o && !valid_o, "no underflow after a read while empty");
      check(rd_count == saved, "read accepted while empty");
      run_cycle(1'b0, 1'b0);
      check(!underflow_o, "underflow_o longer than one cycle");
      end_test("underflow");

      target = wr_count + TEST_WORDS;
      while (rd_count < target) begin
         wr_bit = random_bit();
         rd_bit = random_bit();
         run_cycle(wr_bit && (wr_count < target), rd_bit);
      end
      end_test("random_order");

      // no reads until the FIFO is full, then offer more
      while (!full_o) begin
         run_cycle(1'b1, 1'b0);
      end
      check(wr_count - rd_count >= DEPTH, "full_o before the storage filled");
      saved = wr_count;
      repeat (4) run_cycle(1'b1, 1'b0);
      check(full_o && wr_count == saved, "write accepted while full");
      drain();
      end_test("back_pressure");

      repeat (3) run_cycle(1'b1, 1'b0);
      repeat (4) run_cycle(1'b0, 1'b0);
      check(!almost_empty_o, "almost_empty_o high with three words held");
      drain();
      check(empty_o && almost_empty_o, "flags low after the last read");
      end_test("almost_empty");

      $display("tests run %0d, check errors %0d, assertion failures %0d",
               tests_done, errors, UUT.u_props.fail_cnt);
      if (errors + UUT.u_props.fail_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule
